// File: src/rvMcSettings.svh
`ifndef RVMC_SETTINGS_SVH
`define RVMC_SETTINGS_SVH

// Data and address width
`define RVMC_XLEN 32

// Architectural registers, x0 included
`define RVMC_NREGS 32

// First fetch address
`define RVMC_RESET_PC 32'h0000_0000

// Performance counter width
`define RVMC_CNT_W 32

`endif

// File: src/rvMcPkg.sv
`default_nettype none

package rvMcPkg;

	// Microcode steps of one instruction
	typedef enum logic [2:0] {
		STEP_IF  = 3'd0,
		STEP_ID  = 3'd1,
		STEP_EX  = 3'd2,
		STEP_MEM = 3'd3,
		STEP_WB  = 3'd4
	} uStep;

	// Low three bits follow funct3, bit 3 comes from instr[30]
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_BEQ  = 4'b1001,
		ALU_BNE  = 4'b1010,
		ALU_BLT  = 4'b1011,
		ALU_BGE  = 4'b1100,
		ALU_SRA  = 4'b1101,
		ALU_BLTU = 4'b1110,
		ALU_BGEU = 4'b1111
	} aluOp;

	typedef enum logic [1:0] {
		PC_PLUS4    = 2'b00,
		PC_ALU      = 2'b01,
		PC_ALU_CLR0 = 2'b10, // JALR target
		PC_BRANCH   = 2'b11  // Target only if the compare holds
	} pcSrc;

	typedef enum logic [1:0] {
		RW_PC4 = 2'b00,
		RW_MEM = 2'b01,
		RW_ALU = 2'b10
	} rwSrc;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire

// File: src/rvMcAlu.sv
`default_nettype none
`include "rvMcSettings.svh"

module rvMcAlu (
	input  wire rvMcPkg::aluOp         aluOp,
	input  wire logic [`RVMC_XLEN-1:0] opA,
	input  wire logic [`RVMC_XLEN-1:0] opB,
	output logic [`RVMC_XLEN-1:0]      result,
	output logic                       cmpTrue
);

	localparam int ShW = $clog2(`RVMC_XLEN);

	logic [ShW-1:0] shamt;
	logic           eq;
	logic           ltS;
	logic           ltU;

	assign shamt = opB[ShW-1:0];
	assign eq = (opA == opB);
	assign ltS = $signed(opA) < $signed(opB);
	assign ltU = opA < opB;

	// Six branch conditions
	always_comb
	begin
		case (aluOp)
			rvMcPkg::ALU_BEQ: cmpTrue = eq;
			rvMcPkg::ALU_BNE: cmpTrue = !eq;
			rvMcPkg::ALU_BLT: cmpTrue = ltS;
			rvMcPkg::ALU_BGE: cmpTrue = !ltS;
			rvMcPkg::ALU_BLTU: cmpTrue = ltU;
			rvMcPkg::ALU_BGEU: cmpTrue = !ltU;
			default: cmpTrue = 1'b0;
		endcase
	end

	always_comb
	begin
		case (aluOp)
			rvMcPkg::ALU_ADD: result = opA + opB;
			rvMcPkg::ALU_SUB: result = opA - opB;
			rvMcPkg::ALU_SLL: result = opA << shamt;
			rvMcPkg::ALU_SLT: result = {{(`RVMC_XLEN-1){1'b0}}, ltS};
			rvMcPkg::ALU_SLTU: result = {{(`RVMC_XLEN-1){1'b0}}, ltU};
			rvMcPkg::ALU_XOR: result = opA ^ opB;
			rvMcPkg::ALU_SRL: result = opA >> shamt;
			rvMcPkg::ALU_SRA: result = $unsigned($signed(opA) >>> shamt);
			rvMcPkg::ALU_OR: result = opA | opB;
			rvMcPkg::ALU_AND: result = opA & opB;
			default: result = {{(`RVMC_XLEN-1){1'b0}}, cmpTrue}; // Compare ops
		endcase
	end

endmodule

`default_nettype wire

// File: src/rvMcRegFile.sv
`default_nettype none
`include "rvMcSettings.svh"

module rvMcRegFile (
	input  wire logic                          clk,
	input  wire logic                          arstN,
	input  wire logic [$clog2(`RVMC_NREGS)-1:0] rs1,
	input  wire logic [$clog2(`RVMC_NREGS)-1:0] rs2,
	input  wire logic [$clog2(`RVMC_NREGS)-1:0] rd,
	input  wire logic                          we,
	input  wire logic [`RVMC_XLEN-1:0]         wdata,
	output logic [`RVMC_XLEN-1:0]              rdata1,
	output logic [`RVMC_XLEN-1:0]              rdata2
);

	logic [`RVMC_XLEN-1:0] regs [1:`RVMC_NREGS-1]; // No storage for x0

	always_ff @(posedge clk)
	begin
		if (we && rd != '0)
			regs[rd] <= wdata;
	end

	// Asynchronous reads, x0 reads as zero
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	x0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
		(rs1 == '0 |-> rdata1 == '0) and (rs2 == '0 |-> rdata2 == '0));

endmodule

`default_nettype wire

// File: src/rvMcControl.sv
`default_nettype none
`include "rvMcSettings.svh"

module rvMcControl (
	input  wire logic                  clk,
	input  wire logic                  arstN,
	input  wire logic [`RVMC_XLEN-1:0] instr,
	input  wire logic                  branchTaken,
	input  wire logic                  memAck,
	output logic                       memReq,
	output logic                       memWe,
	output logic                       iorD,
	output logic                       pcWrite,
	output logic                       irWrite,
	output logic                       mdrWrite,
	output logic                       rfWe,
	output logic                       aluSrcA, // 0 PC, 1 A register
	output logic                       aluSrcB, // 0 B register, 1 immediate
	output rvMcPkg::aluOp              aluOp,
	output rvMcPkg::pcSrc              pcSrc,
	output rvMcPkg::rwSrc              rwSrc,
	output logic                       retire
);

	rvMcPkg::uStep step;
	rvMcPkg::uStep stepNext;
	logic          ackSeen; // Ack captured and waiting for it to fall
	logic          memReqNext;
	logic          ackSeenNext;
	logic [6:0]    opcode;
	logic [2:0]    funct3;
	logic          memStep;
	logic          capture;
	logic          memDone;
	logic          isStore;
	logic          isLoad;
	logic          supported;
	rvMcPkg::aluOp rOp;
	rvMcPkg::aluOp iOp;
	rvMcPkg::aluOp bOp;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign isLoad = (opcode == rvMcPkg::OPC_LOAD) && (funct3 == 3'b010);
	assign isStore = (opcode == rvMcPkg::OPC_STORE) && (funct3 == 3'b010);
	assign supported = isLoad || isStore || (opcode == rvMcPkg::OPC_OP) ||
		(opcode == rvMcPkg::OPC_OPIMM) || (opcode == rvMcPkg::OPC_BRANCH) ||
		(opcode == rvMcPkg::OPC_JAL) || (opcode == rvMcPkg::OPC_JALR);

	// Bit 30 selects only SUB and SRA
	assign rOp = rvMcPkg::aluOp'({instr[30] && (funct3 == 3'b000 || funct3 == 3'b101), funct3});
	assign iOp = rvMcPkg::aluOp'({instr[30] && (funct3 == 3'b101), funct3});

	always_comb
	begin
		case (funct3)
			3'b001: bOp = rvMcPkg::ALU_BNE;
			3'b100: bOp = rvMcPkg::ALU_BLT;
			3'b101: bOp = rvMcPkg::ALU_BGE;
			3'b110: bOp = rvMcPkg::ALU_BLTU;
			3'b111: bOp = rvMcPkg::ALU_BGEU;
			default: bOp = rvMcPkg::ALU_BEQ;
		endcase
	end

	// Four-phase handshake shared by IF and MEM
	assign memStep = (step == rvMcPkg::STEP_IF) || (step == rvMcPkg::STEP_MEM);
	assign capture = memReq && memAck;
	assign memDone = ackSeen && !memAck;

	always_comb
	begin
		memReqNext = memReq;
		ackSeenNext = ackSeen;
		if (memStep)
		begin
			if (!memReq && !ackSeen && !memAck)
				memReqNext = 1'b1;
			else if (capture)
			begin
				memReqNext = 1'b0;
				ackSeenNext = 1'b1;
			end
			else if (memDone)
				ackSeenNext = 1'b0;
		end
	end

	assign irWrite = (step == rvMcPkg::STEP_IF) && capture;
	assign mdrWrite = (step == rvMcPkg::STEP_MEM) && capture && isLoad;
	assign memWe = (step == rvMcPkg::STEP_MEM) && memReq && isStore;

	always_comb
	begin
		stepNext = step;
		pcWrite = 1'b0;
		rfWe = 1'b0;
		iorD = 1'b0;
		aluSrcA = 1'b0;
		aluSrcB = 1'b1;
		aluOp = rvMcPkg::ALU_ADD;
		pcSrc = rvMcPkg::PC_PLUS4;
		rwSrc = rvMcPkg::RW_ALU;
		retire = 1'b0;
		case (step)
			rvMcPkg::STEP_IF:
			begin
				if (memDone)
					stepNext = rvMcPkg::STEP_ID;
			end
			rvMcPkg::STEP_ID:
			begin
				// ALU forms PC + imm as the branch target for EX
				stepNext = rvMcPkg::STEP_EX;
				if (!supported)
				begin
					pcWrite = 1'b1; // Unknown opcode retires as a no-op
					retire = 1'b1;
					stepNext = rvMcPkg::STEP_IF;
				end
			end
			rvMcPkg::STEP_EX:
			begin
				pcWrite = 1'b1;
				aluSrcA = 1'b1;
				stepNext = rvMcPkg::STEP_WB;
				case (opcode)
					rvMcPkg::OPC_BRANCH:
					begin
						aluSrcB = 1'b0;
						aluOp = bOp;
						pcSrc = rvMcPkg::PC_BRANCH;
						retire = 1'b1;
						stepNext = rvMcPkg::STEP_IF;
					end
					rvMcPkg::OPC_JAL:
					begin
						aluSrcA = 1'b0;
						pcSrc = rvMcPkg::PC_ALU;
					end
					rvMcPkg::OPC_JALR: pcSrc = rvMcPkg::PC_ALU_CLR0;
					rvMcPkg::OPC_LOAD, rvMcPkg::OPC_STORE: stepNext = rvMcPkg::STEP_MEM;
					rvMcPkg::OPC_OP:
					begin
						aluSrcB = 1'b0;
						aluOp = rOp;
					end
					rvMcPkg::OPC_OPIMM: aluOp = iOp;
					default: stepNext = rvMcPkg::STEP_IF;
				endcase
			end
			rvMcPkg::STEP_MEM:
			begin
				aluSrcA = 1'b1; // Keeps the address in the ALU result register
				iorD = 1'b1;
				if (memDone)
				begin
					if (isStore)
					begin
						retire = 1'b1;
						stepNext = rvMcPkg::STEP_IF;
					end
					else
						stepNext = rvMcPkg::STEP_WB;
				end
			end
			rvMcPkg::STEP_WB:
			begin
				rfWe = 1'b1;
				retire = 1'b1;
				stepNext = rvMcPkg::STEP_IF;
				if (opcode == rvMcPkg::OPC_JAL || opcode == rvMcPkg::OPC_JALR)
					rwSrc = rvMcPkg::RW_PC4;
				else if (isLoad)
					rwSrc = rvMcPkg::RW_MEM;
			end
			default: stepNext = rvMcPkg::STEP_IF;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			step <= rvMcPkg::STEP_IF;
			memReq <= 1'b0;
			ackSeen <= 1'b0;
		end
		else
		begin
			step <= stepNext;
			memReq <= memReqNext;
			ackSeen <= ackSeenNext;
		end
	end

	reqHeldUntilAck: assert property (@(posedge clk) disable iff (!arstN)
		$fell(memReq) |-> $past(memAck));

	rfWriteOnlyInWb: assert property (@(posedge clk) disable iff (!arstN)
		rfWe |-> step == rvMcPkg::STEP_WB);

	stepLegal: assert property (@(posedge clk) disable iff (!arstN)
		step inside {rvMcPkg::STEP_IF, rvMcPkg::STEP_ID, rvMcPkg::STEP_EX,
			rvMcPkg::STEP_MEM, rvMcPkg::STEP_WB});

endmodule

`default_nettype wire

// File: src/rvMcDatapath.sv
`default_nettype none
`include "rvMcSettings.svh"

module rvMcDatapath (
	input  wire logic                  clk,
	input  wire logic                  arstN,
	input  wire logic                  pcWrite,
	input  wire logic                  irWrite,
	input  wire logic                  mdrWrite,
	input  wire logic                  rfWe,
	input  wire logic                  aluSrcA,
	input  wire logic                  aluSrcB,
	input  wire rvMcPkg::aluOp         aluOp,
	input  wire rvMcPkg::pcSrc         pcSrc,
	input  wire rvMcPkg::rwSrc         rwSrc,
	input  wire logic                  iorD,
	input  wire logic [`RVMC_XLEN-1:0] memRdata,
	output logic [`RVMC_XLEN-1:0]      instr,
	output logic                       branchTaken,
	output logic [`RVMC_XLEN-1:0]      memAddr,
	output logic [`RVMC_XLEN-1:0]      memWdata
);

	logic [`RVMC_XLEN-1:0] pc;
	logic [`RVMC_XLEN-1:0] pcPlus4; // Return address of the current instruction
	logic [`RVMC_XLEN-1:0] pcNext;
	logic [`RVMC_XLEN-1:0] ir;
	logic [`RVMC_XLEN-1:0] a;
	logic [`RVMC_XLEN-1:0] b;
	logic [`RVMC_XLEN-1:0] aluOut;
	logic [`RVMC_XLEN-1:0] mdr;
	logic [`RVMC_XLEN-1:0] imm;
	logic [`RVMC_XLEN-1:0] opA;
	logic [`RVMC_XLEN-1:0] opB;
	logic [`RVMC_XLEN-1:0] aluResult;
	logic [`RVMC_XLEN-1:0] rdata1;
	logic [`RVMC_XLEN-1:0] rdata2;
	logic [`RVMC_XLEN-1:0] rfWdata;
	logic                  cmpTrue;

	assign instr = ir;

	// Immediate format follows the opcode, I-type otherwise
	always_comb
	begin
		case (ir[6:0])
			rvMcPkg::OPC_STORE: imm = {{(`RVMC_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
			rvMcPkg::OPC_BRANCH:
				imm = {{(`RVMC_XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
			rvMcPkg::OPC_JAL:
				imm = {{(`RVMC_XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
			default: imm = {{(`RVMC_XLEN-12){ir[31]}}, ir[31:20]};
		endcase
	end

	assign opA = aluSrcA ? a : pc;
	assign opB = aluSrcB ? imm : b;
	assign branchTaken = cmpTrue;

	rvMcAlu u_rvMcAlu (
		.aluOp  (aluOp),
		.opA    (opA),
		.opB    (opB),
		.result (aluResult),
		.cmpTrue(cmpTrue)
	);

	always_comb
	begin
		case (rwSrc)
			rvMcPkg::RW_PC4: rfWdata = pcPlus4;
			rvMcPkg::RW_MEM: rfWdata = mdr;
			default: rfWdata = aluOut;
		endcase
	end

	rvMcRegFile u_rvMcRegFile (
		.clk   (clk),
		.arstN (arstN),
		.rs1   (ir[19:15]),
		.rs2   (ir[24:20]),
		.rd    (ir[11:7]),
		.we    (rfWe),
		.wdata (rfWdata),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	always_comb
	begin
		case (pcSrc)
			rvMcPkg::PC_ALU: pcNext = aluResult;
			rvMcPkg::PC_ALU_CLR0: pcNext = {aluResult[`RVMC_XLEN-1:1], 1'b0};
			rvMcPkg::PC_BRANCH: pcNext = branchTaken ? aluOut : pcPlus4; // Target from ID
			default: pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			pc <= `RVMC_RESET_PC;
		else if (pcWrite)
			pc <= pcNext;
	end

	always_ff @(posedge clk)
	begin
		if (irWrite)
		begin
			ir <= memRdata;
			pcPlus4 <= pc + `RVMC_XLEN'd4;
		end
		if (mdrWrite)
			mdr <= memRdata;
		a <= rdata1;
		b <= rdata2;
		aluOut <= aluResult; // Reloaded every step
	end

	assign memAddr = iorD ? aluOut : pc;
	assign memWdata = b;

endmodule

`default_nettype wire

// File: src/rvMcPerfCounter.sv
`default_nettype none
`include "rvMcSettings.svh"

module rvMcPerfCounter (
	input  wire logic                   clk,
	input  wire logic                   arstN,
	input  wire logic                   retire,
	output logic [`RVMC_CNT_W-1:0]      instCount,
	output logic [`RVMC_CNT_W-1:0]      cycleCount
);

	// Both wrap at the counter width
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			instCount <= '0;
			cycleCount <= '0;
		end
		else
		begin
			cycleCount <= cycleCount + 1'b1;
			if (retire)
				instCount <= instCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/rvMcCore.sv
`default_nettype none
`include "rvMcSettings.svh"

module rvMcCore (
	input  wire logic                  clk,
	input  wire logic                  arstN,
	input  wire logic                  memAck,
	input  wire logic [`RVMC_XLEN-1:0] memRdata,
	output logic                       memReq,
	output logic                       memWe,
	output logic [`RVMC_XLEN-1:0]      memAddr,
	output logic [`RVMC_XLEN-1:0]      memWdata,
	output logic                       retire,
	output logic [`RVMC_CNT_W-1:0]     instCount,
	output logic [`RVMC_CNT_W-1:0]     cycleCount
);

	logic                  pcWrite;
	logic                  irWrite;
	logic                  mdrWrite;
	logic                  rfWe;
	logic                  aluSrcA;
	logic                  aluSrcB;
	logic                  iorD; // Data address instead of PC
	logic                  branchTaken;
	logic [`RVMC_XLEN-1:0] instr;
	rvMcPkg::aluOp         aluOp;
	rvMcPkg::pcSrc         pcSrc;
	rvMcPkg::rwSrc         rwSrc;

	rvMcControl u_rvMcControl (
		.clk        (clk),
		.arstN      (arstN),
		.instr      (instr),
		.branchTaken(branchTaken),
		.memAck     (memAck),
		.memReq     (memReq),
		.memWe      (memWe),
		.iorD       (iorD),
		.pcWrite    (pcWrite),
		.irWrite    (irWrite),
		.mdrWrite   (mdrWrite),
		.rfWe       (rfWe),
		.aluSrcA    (aluSrcA),
		.aluSrcB    (aluSrcB),
		.aluOp      (aluOp),
		.pcSrc      (pcSrc),
		.rwSrc      (rwSrc),
		.retire     (retire)
	);

	rvMcDatapath u_rvMcDatapath (
		.clk        (clk),
		.arstN      (arstN),
		.pcWrite    (pcWrite),
		.irWrite    (irWrite),
		.mdrWrite   (mdrWrite),
		.rfWe       (rfWe),
		.aluSrcA    (aluSrcA),
		.aluSrcB    (aluSrcB),
		.aluOp      (aluOp),
		.pcSrc      (pcSrc),
		.rwSrc      (rwSrc),
		.iorD       (iorD),
		.memRdata   (memRdata),
		.instr      (instr),
		.branchTaken(branchTaken),
		.memAddr    (memAddr),
		.memWdata   (memWdata)
	);

	rvMcPerfCounter u_rvMcPerfCounter (
		.clk       (clk),
		.arstN     (arstN),
		.retire    (retire),
		.instCount (instCount),
		.cycleCount(cycleCount)
	);

endmodule

`default_nettype wire

// File: dv/rvMcClock.sv
`default_nettype none

module rvMcClock #(
	parameter int ResetCycles = 5
) (
	output logic clk,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial
	begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/rvMcTb.sv
`default_nettype none
`include "rvMcSettings.svh"

module rvMcTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumInstr = 200;
	localparam int MemWords = 512;
	localparam logic [31:0] LastPc = 32'((NumInstr - 1) * 4);

	logic                   clk;
	logic                   arstN;
	logic                   memAck = 1'b0;
	logic [`RVMC_XLEN-1:0]  memRdata = '0;
	logic                   memReq;
	logic                   memWe;
	logic [`RVMC_XLEN-1:0]  memAddr;
	logic [`RVMC_XLEN-1:0]  memWdata;
	logic                   retire;
	logic [`RVMC_CNT_W-1:0] instCount;
	logic [`RVMC_CNT_W-1:0] cycleCount;

	logic [31:0] lfsr = 32'h51480d5a;
	logic [31:0] mem [MemWords];    // Memory behind the DUT port
	logic [31:0] refMem [MemWords]; // Reference model copy
	logic [31:0] refReg [32];
	logic [31:0] modelPc = `RVMC_RESET_PC;
	logic [31:0] pendAddr = '0;
	logic [31:0] pendData = '0;
	logic        pendStore = 1'b0;
	logic        expectFetch = 1'b1;
	logic        lastSeen = 1'b0;
	logic        done = 1'b0;
	int          executed = 0;
	int          retireCount = 0;
	int          sinceRetire = 0;
	int          waitLeft = -1;
	logic        prevReq = 1'b0;
	logic        prevAck = 1'b0;
	logic        prevWe = 1'b0;
	logic [31:0] prevAddr = '0;
	logic [31:0] prevCycle = '0;

	rvMcClock u_rvMcClock (.clk(clk), .arstN(arstN));

	rvMcCore u_rvMcCore (
		.clk       (clk),
		.arstN     (arstN),
		.memAck    (memAck),
		.memRdata  (memRdata),
		.memReq    (memReq),
		.memWe     (memWe),
		.memAddr   (memAddr),
		.memWdata  (memWdata),
		.retire    (retire),
		.instCount (instCount),
		.cycleCount(cycleCount)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] randBits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else
		begin
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	// RV32I integer ops, alt selects SUB and SRA
	function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic takenRef(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic buildProgram();
		logic [31:0] in;
		logic [11:0] imm;
		logic [11:0] dimm;
		logic [20:0] off;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic        alt;
		int          kind;
		int          k;
		for (int w = 0; w < MemWords; w++)
			mem[w] = (w * 32'h9e37_79b1) ^ {w[15:0], 16'h5a3c};
		for (int i = 0; i < NumInstr; i++)
		begin
			kind = int'(randBits(4));
			f3 = 3'(randBits(3));
			rd = 5'(randBits(3));
			rs1 = 5'(randBits(3));
			rs2 = 5'(randBits(3));
			alt = randBits(1) != 0;
			imm = 12'(randBits(12));
			dimm = {2'b01, 2'b00, 6'(randBits(6)), 2'b00}; // Data words at 0x400
			k = 1 + int'(randBits(2));
			if (k > NumInstr - 1 - i)
				k = NumInstr - 1 - i; // Never past the final loop
			off = 21'(4 * k);
			if (i < 7)
				in = {imm, 5'd0, 3'd0, 5'(i + 1), rvMcPkg::OPC_OPIMM}; // Seeds x1 to x7
			else if (i == NumInstr - 1)
				in = {25'd0, rvMcPkg::OPC_JAL};
			else if (kind < 5)
				in = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2, rs1, f3, rd,
					rvMcPkg::OPC_OP};
			else if (kind < 9)
			begin
				if (f3 == 3'd1 || f3 == 3'd5)
					imm = {1'b0, alt && f3 == 3'd5, 5'd0, imm[4:0]}; // Legal shift forms
				in = {imm, rs1, f3, rd, rvMcPkg::OPC_OPIMM};
			end
			else if (kind < 11)
				in = {dimm, 5'd0, 3'b010, rd, rvMcPkg::OPC_LOAD};
			else if (kind < 13)
				in = {dimm[11:5], rs2, 5'd0, 3'b010, dimm[4:0], rvMcPkg::OPC_STORE};
			else if (kind < 15)
			begin
				if (f3[2:1] == 2'b01)
					f3 = {2'b00, f3[0]};
				in = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvMcPkg::OPC_BRANCH};
			end
			else if (alt)
				in = {off[20], off[10:1], off[11], off[19:12], rd, rvMcPkg::OPC_JAL};
			else
				in = {12'(4 * (i + k)), 5'd0, 3'd0, rd, rvMcPkg::OPC_JALR};
			mem[i] = in;
		end
		refMem = mem;
		foreach (refReg[r])
			refReg[r] = '0;
	endtask

	// Whole instruction at its fetch, data access noted for the next request
	task automatic modelStep();
		logic [31:0] in;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] res;
		logic [31:0] nextPc;
		logic        wr;
		in = refMem[modelPc[10:2]];
		a = refReg[in[19:15]];
		b = refReg[in[24:20]];
		immI = {{20{in[31]}}, in[31:20]};
		nextPc = modelPc + 32'd4;
		res = modelPc + 32'd4;
		wr = 1'b1;
		case (in[6:0])
			rvMcPkg::OPC_OP: res = aluRef(in[14:12], in[30], a, b);
			rvMcPkg::OPC_OPIMM: res = aluRef(in[14:12], in[30] && in[14:12] == 3'd5, a, immI);
			rvMcPkg::OPC_LOAD:
			begin
				pendAddr = a + immI;
				pendStore = 1'b0;
				expectFetch = 1'b0;
				res = refMem[pendAddr[10:2]];
			end
			rvMcPkg::OPC_STORE:
			begin
				pendAddr = a + {{20{in[31]}}, in[31:25], in[11:7]};
				pendData = b;
				pendStore = 1'b1;
				expectFetch = 1'b0;
				refMem[pendAddr[10:2]] = b;
				wr = 1'b0;
			end
			rvMcPkg::OPC_BRANCH:
			begin
				wr = 1'b0;
				if (takenRef(in[14:12], a, b))
					nextPc = modelPc + {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
			end
			rvMcPkg::OPC_JAL: nextPc = modelPc + {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
			rvMcPkg::OPC_JALR: nextPc = (a + immI) & ~32'd1;
			default: wr = 1'b0;
		endcase
		if (wr && in[11:7] != 5'd0)
			refReg[in[11:7]] = res;
		modelPc = nextPc;
		executed++;
	endtask

	// Four-phase memory with 0 to 7 cycles of latency
	always @(posedge clk)
	begin
		if (!arstN)
		begin
			memAck <= 1'b0;
			waitLeft = -1;
		end
		else if (memAck)
		begin
			if (!memReq)
				memAck <= 1'b0;
		end
		else if (memReq)
		begin
			if (waitLeft < 0)
				waitLeft = int'(randBits(3));
			if (waitLeft == 0)
			begin
				if (memWe)
					mem[memAddr[10:2]] = memWdata;
				else
					memRdata <= mem[memAddr[10:2]];
				memAck <= 1'b1;
				waitLeft = -1;
			end
			else
				waitLeft--;
		end
	end

	always @(posedge clk)
	begin
		if (!arstN)
		begin
			assert (memReq === 1'b0) else
			begin
				$display("memReq was raised while reset was asserted");
				abortRun();
			end
		end
		else
		begin
			if (retire)
			begin
				retireCount++;
				sinceRetire = 0;
			end
			else
				sinceRetire++;
			assert (sinceRetire <= 100) else
			begin
				$display("No instruction retired within 100 cycles of the previous one");
				abortRun();
			end
			assert (cycleCount >= prevCycle) else
			begin
				$display("FAILED cycleCount 0x%h fell from 0x%h", cycleCount, prevCycle);
				abortRun();
			end
			if (prevReq && !prevAck) // Request must hold until acknowledged
			begin
				assert (memReq) else
				begin
					$display("memReq dropped before memAck was raised");
					abortRun();
				end
				checkValue("memAddr", memAddr, prevAddr);
				checkValue("memWe", 32'(memWe), 32'(prevWe));
			end
			if (memReq && !prevReq && !done)
			begin
				assert (!prevAck) else
				begin
					$display("memReq was raised while memAck was still high");
					abortRun();
				end
				if (expectFetch)
				begin
					checkValue("memWe", 32'(memWe), 32'd0);
					checkValue("memAddr", memAddr, modelPc);
					if (modelPc == LastPc)
					begin
						done = lastSeen; // Second visit ends the run
						lastSeen = 1'b1;
					end
					if (!done)
						modelStep();
				end
				else
				begin
					checkValue("memWe", 32'(memWe), 32'(pendStore));
					checkValue("memAddr", memAddr, pendAddr);
					if (pendStore)
						checkValue("memWdata", memWdata, pendData);
					expectFetch = 1'b1;
				end
			end
			prevCycle = cycleCount;
		end
		prevReq = memReq;
		prevAck = memAck;
		prevAddr = memAddr;
		prevWe = memWe;
	end

	initial
	begin
		int n;
		buildProgram();
		n = 0;
		while (arstN !== 1'b1 && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		assert (arstN === 1'b1) else
		begin
			$display("Reset was never released");
			abortRun();
		end
		n = 0;
		while (!done && n < 100000)
		begin
			@(negedge clk);
			n++;
		end
		assert (done) else
		begin
			$display("The program never reached its final loop");
			abortRun();
		end
		checkValue("instCount", instCount, 32'(retireCount));
		checkValue("instCount", instCount, 32'(executed));
		assert (cycleCount >= 4 * instCount) else
		begin
			$display("FAILED cycleCount 0x%h below 4 x instCount 0x%h", cycleCount, instCount);
			abortRun();
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: rvMcCore.f
+incdir+src
src/rvMcPkg.sv
src/rvMcAlu.sv
src/rvMcRegFile.sv
src/rvMcControl.sv
src/rvMcDatapath.sv
src/rvMcPerfCounter.sv
src/rvMcCore.sv
dv/rvMcClock.sv
dv/rvMcTb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall
TOP        := rvMcTb
FILELIST   := rvMcCore.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
